// File: design/opb_register_ppc2simulink.sv
`timescale 1ns/1ps
`default_nettype none

module opb_register_ppc2simulink (
  input  wire                                      OPB_Clk,
  input  wire                                      rst_n,
  input  wire  [0:opb_regs_pkg::OPB_AWIDTH-1]      opb_abus,
  input  wire  [0:opb_regs_pkg::OPB_BEWIDTH-1]     opb_be,
  input  wire  [0:opb_regs_pkg::OPB_DWIDTH-1]      opb_dbus,
  input  wire                                      opb_rnw,
  input  wire                                      opb_select,
  input  wire                                      user_clk,
  output logic [0:opb_regs_pkg::OPB_DWIDTH-1]      sl_dbus,
  output logic                                     sl_xfer_ack,
  output logic [opb_regs_pkg::OPB_DWIDTH-1:0]      user_data_out
);

  import opb_regs_pkg::*;

  logic                    hit;
  logic                    wr_xfer;
  logic                    busy;
  logic                    launch;

  // bus domain state.
  logic [0:OPB_DWIDTH-1]   reg_word;
  logic [0:OPB_DWIDTH-1]   xfer_word;
  logic                    dirty;
  logic                    xfer_req;
  logic                    ack_r;
  logic                    ack_rr;

  // user domain state.
  logic                    req_r;
  logic                    req_rr;
  logic                    user_ack;

  // --------------------------------------------------
  // bus side
  // --------------------------------------------------
  assign hit     = opb_select && (opb_abus >= P2S_BASEADDR) && (opb_abus <= P2S_HIGHADDR);
  assign wr_xfer = hit && !sl_xfer_ack && !opb_rnw;

  // a transfer is in flight until the user side toggles back.
  assign busy   = xfer_req != ack_rr;
  assign launch = dirty && !busy;

  always_ff @(posedge OPB_Clk) begin
    ack_r  <= user_ack;
    ack_rr <= ack_r;
  end

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      sl_xfer_ack <= 1'b0;
      dirty       <= 1'b0;
      xfer_req    <= 1'b0;
      reg_word    <= '0;
    end else begin
      sl_xfer_ack <= hit && !sl_xfer_ack;

      if (launch) begin
        xfer_req <= ~xfer_req;
        dirty    <= 1'b0;
      end

      // a write during a transfer only marks the word for one more.
      if (wr_xfer) begin
        for (int i = 0; i < OPB_BEWIDTH; i++) begin
          if (opb_be[i]) begin
            reg_word[8*i +: 8] <= opb_dbus[8*i +: 8];
          end
        end
        dirty <= 1'b1;
      end
    end
  end

  // held copy for the user domain, stable while busy.
  always_ff @(posedge OPB_Clk) begin
    if (launch) begin
      xfer_word <= reg_word;
    end
  end

  assign sl_dbus = (sl_xfer_ack && opb_rnw) ? reg_word : '0;

  // --------------------------------------------------
  // user side
  // --------------------------------------------------
  always_ff @(posedge user_clk) begin
    req_r    <= xfer_req;
    req_rr   <= req_r;
    user_ack <= req_rr;

    // each toggle of the request copies the held word.
    if (req_rr != user_ack) begin
      user_data_out <= xfer_word;
    end
  end

endmodule

`default_nettype wire

// File: design/opb_register_simulink2ppc.sv
`timescale 1ns/1ps
`default_nettype none

module opb_register_simulink2ppc (
  input  wire                                      OPB_Clk,
  input  wire                                      rst_n,
  input  wire  [0:opb_regs_pkg::OPB_AWIDTH-1]      opb_abus,
  input  wire  [0:opb_regs_pkg::OPB_BEWIDTH-1]     opb_be,
  input  wire                                      opb_rnw,
  input  wire                                      opb_select,
  input  wire                                      user_clk,
  input  wire  [opb_regs_pkg::OPB_DWIDTH-1:0]      user_data_in,
  output logic [0:opb_regs_pkg::OPB_DWIDTH-1]      sl_dbus,
  output logic                                     sl_xfer_ack
);

  import opb_regs_pkg::*;

  logic                    hit;
  logic                    new_xfer;

  // bus domain handshake state.
  logic                    register_request;
  logic                    ready_r;
  logic                    ready_rr;
  logic                    buf_lock;
  logic [0:OPB_DWIDTH-1]   register_buffer;

  // user domain handshake state.
  logic                    request_r;
  logic                    request_rr;
  logic                    register_ready;
  logic [OPB_DWIDTH-1:0]   user_data_reg;

  // --------------------------------------------------
  // bus side
  // --------------------------------------------------
  assign hit = opb_select && (opb_abus >= S2P_BASEADDR) && (opb_abus <= S2P_HIGHADDR);

  // the ack register must be low first, so one select gives one ack.
  assign new_xfer = hit && !sl_xfer_ack;

  // ready synchronizer into the OPB clock.
  always_ff @(posedge OPB_Clk) begin
    ready_r  <= register_ready;
    ready_rr <= ready_r;
  end

  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      sl_xfer_ack      <= 1'b0;
      buf_lock         <= 1'b0;
      register_request <= 1'b0;
      register_buffer  <= '0;
    end else begin
      sl_xfer_ack <= new_xfer;

      // upper half read locks, lower half read unlocks.
      // a full word read does both and ends unlocked.
      if (new_xfer && opb_rnw) begin
        if (opb_be[0]) begin
          buf_lock <= 1'b1;
        end
        if (opb_be[OPB_BEWIDTH-1]) begin
          buf_lock <= 1'b0;
        end
      end

      // a locked buffer skips the capture and the next loop retries.
      if (ready_rr && register_request && !buf_lock) begin
        register_buffer <= user_data_reg;
      end

      // request stays up until ready comes back, then drops.
      if (ready_rr) begin
        register_request <= 1'b0;
      end else begin
        register_request <= 1'b1;
      end
    end
  end

  // data only during a read ack, zero otherwise.
  assign sl_dbus = (sl_xfer_ack && opb_rnw) ? register_buffer : '0;

  // --------------------------------------------------
  // user side
  // --------------------------------------------------
  always_ff @(posedge user_clk) begin
    request_r  <= register_request;
    request_rr <= request_r;

    if (!request_rr) begin
      register_ready <= 1'b0;
    end else if (!register_ready) begin
      // sample the user value once on a rising request.
      register_ready <= 1'b1;
      user_data_reg  <= user_data_in;
    end
  end

endmodule

`default_nettype wire

// File: design/opb_regs_pkg.sv
`default_nettype none

package opb_regs_pkg;

  // --------------------------------------------------
  // OPB bus widths.
  // --------------------------------------------------
  localparam int OPB_AWIDTH  = 32;
  localparam int OPB_DWIDTH  = 32;
  localparam int OPB_BEWIDTH = OPB_DWIDTH / 8;

  // --------------------------------------------------
  // address map, one window per software register.
  // --------------------------------------------------

  // read-only register, user design to processor.
  localparam logic [0:OPB_AWIDTH-1] S2P_BASEADDR = 32'h0000_0000;
  localparam logic [0:OPB_AWIDTH-1] S2P_HIGHADDR = 32'h0000_00FF;

  // write register, processor to user design.
  localparam logic [0:OPB_AWIDTH-1] P2S_BASEADDR = 32'h0000_0100;
  localparam logic [0:OPB_AWIDTH-1] P2S_HIGHADDR = 32'h0000_01FF;

endpackage

`default_nettype wire

// File: design/opb_slave_mux.sv
`timescale 1ns/1ps
`default_nettype none

module opb_slave_mux (
  input  wire                                      OPB_Clk,
  input  wire                                      rst_n,
  input  wire  [0:opb_regs_pkg::OPB_AWIDTH-1]      opb_abus,
  input  wire                                      opb_select,
  input  wire  [0:opb_regs_pkg::OPB_DWIDTH-1]      s2p_dbus,
  input  wire                                      s2p_xfer_ack,
  input  wire  [0:opb_regs_pkg::OPB_DWIDTH-1]      p2s_dbus,
  input  wire                                      p2s_xfer_ack,
  output logic [0:opb_regs_pkg::OPB_DWIDTH-1]      sl_dbus,
  output logic                                     sl_xfer_ack,
  output logic                                     sl_err_ack
);

  import opb_regs_pkg::*;

  logic s2p_map;
  logic p2s_map;
  logic unmapped;

  // --------------------------------------------------
  // data and ack combine
  // --------------------------------------------------

  // each slave drives zero when idle, so an OR is enough.
  assign sl_dbus     = s2p_dbus | p2s_dbus;
  assign sl_xfer_ack = s2p_xfer_ack | p2s_xfer_ack;

  // --------------------------------------------------
  // unmapped address error
  // --------------------------------------------------
  assign s2p_map  = (opb_abus >= S2P_BASEADDR) && (opb_abus <= S2P_HIGHADDR);
  assign p2s_map  = (opb_abus >= P2S_BASEADDR) && (opb_abus <= P2S_HIGHADDR);
  assign unmapped = opb_select && !s2p_map && !p2s_map;

  // same one cycle timing as the slave acks.
  always_ff @(posedge OPB_Clk) begin
    if (!rst_n) begin
      sl_err_ack <= 1'b0;
    end else begin
      sl_err_ack <= unmapped && !sl_err_ack;
    end
  end

endmodule

`default_nettype wire

// File: design/opb_sw_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module opb_sw_reg_bank (
  input  wire                                      OPB_Clk,
  input  wire                                      rst_n,
  input  wire  [0:opb_regs_pkg::OPB_AWIDTH-1]      OPB_ABus,
  input  wire  [0:opb_regs_pkg::OPB_BEWIDTH-1]     OPB_BE,
  input  wire  [0:opb_regs_pkg::OPB_DWIDTH-1]      OPB_DBus,
  input  wire                                      OPB_RNW,
  input  wire                                      OPB_select,
  input  wire                                      OPB_seqAddr,
  input  wire                                      user_clk,
  input  wire  [opb_regs_pkg::OPB_DWIDTH-1:0]      user_data_in,
  output logic [opb_regs_pkg::OPB_DWIDTH-1:0]      user_data_out,
  output logic [0:opb_regs_pkg::OPB_DWIDTH-1]      Sl_DBus,
  output logic                                     Sl_xferAck,
  output logic                                     Sl_errAck,
  output logic                                     Sl_retry,
  output logic                                     Sl_toutSup
);

  import opb_regs_pkg::*;

  logic [0:OPB_DWIDTH-1] s2p_dbus;
  logic                  s2p_xfer_ack;
  logic [0:OPB_DWIDTH-1] p2s_dbus;
  logic                  p2s_xfer_ack;

  // no retry or timeout suppression, every access completes in one cycle.
  // OPB_seqAddr is a burst hint, single beats only here.
  assign Sl_retry   = 1'b0;
  assign Sl_toutSup = 1'b0;

  // --------------------------------------------------
  // software registers
  // --------------------------------------------------
  opb_register_simulink2ppc u_s2p (
    .OPB_Clk      (OPB_Clk),
    .rst_n        (rst_n),
    .opb_abus     (OPB_ABus),
    .opb_be       (OPB_BE),
    .opb_rnw      (OPB_RNW),
    .opb_select   (OPB_select),
    .user_clk     (user_clk),
    .user_data_in (user_data_in),
    .sl_dbus      (s2p_dbus),
    .sl_xfer_ack  (s2p_xfer_ack)
  );

  opb_register_ppc2simulink u_p2s (
    .OPB_Clk       (OPB_Clk),
    .rst_n         (rst_n),
    .opb_abus      (OPB_ABus),
    .opb_be        (OPB_BE),
    .opb_dbus      (OPB_DBus),
    .opb_rnw       (OPB_RNW),
    .opb_select    (OPB_select),
    .user_clk      (user_clk),
    .sl_dbus       (p2s_dbus),
    .sl_xfer_ack   (p2s_xfer_ack),
    .user_data_out (user_data_out)
  );

  // --------------------------------------------------
  // slave output mux
  // --------------------------------------------------
  opb_slave_mux u_mux (
    .OPB_Clk      (OPB_Clk),
    .rst_n        (rst_n),
    .opb_abus     (OPB_ABus),
    .opb_select   (OPB_select),
    .s2p_dbus     (s2p_dbus),
    .s2p_xfer_ack (s2p_xfer_ack),
    .p2s_dbus     (p2s_dbus),
    .p2s_xfer_ack (p2s_xfer_ack),
    .sl_dbus      (Sl_DBus),
    .sl_xfer_ack  (Sl_xferAck),
    .sl_err_ack   (Sl_errAck)
  );

endmodule

`default_nettype wire

// File: project.f
design/opb_regs_pkg.sv
design/opb_register_simulink2ppc.sv
design/opb_register_ppc2simulink.sv
design/opb_slave_mux.sv
design/opb_sw_reg_bank.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: verif/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input wire                                  OPB_Clk,
  input wire                                  rst_n,
  input wire [0:opb_regs_pkg::OPB_AWIDTH-1]   OPB_ABus,
  input wire [0:opb_regs_pkg::OPB_BEWIDTH-1]  OPB_BE,
  input wire [0:opb_regs_pkg::OPB_DWIDTH-1]   OPB_DBus,
  input wire                                  OPB_RNW,
  input wire                                  OPB_select,
  input wire [opb_regs_pkg::OPB_DWIDTH-1:0]   user_data_in,
  input wire [opb_regs_pkg::OPB_DWIDTH-1:0]   user_data_out,
  input wire [0:opb_regs_pkg::OPB_DWIDTH-1]   Sl_DBus,
  input wire                                  Sl_xferAck,
  input wire                                  Sl_errAck,
  input wire                                  Sl_retry,
  input wire                                  Sl_toutSup
);

  import opb_regs_pkg::*;

  int                     check_count = 0;
  int                     err_count   = 0;
  int                     test_errs   = 0;
  int                     test_num    = 0;
  logic [0:OPB_DWIDTH-1]  p2s_model   = '0;
  logic [0:OPB_DWIDTH-1]  s2p_cur     = '0;
  logic                   s2p_lock    = 1'b0;

  // transfer in flight as captured when select rises.
  logic                   pending     = 1'b0;
  logic                   sel_prev    = 1'b0;
  int                     age         = 0;
  logic [0:OPB_AWIDTH-1]  xfer_addr;
  logic [0:OPB_BEWIDTH-1] xfer_be;
  logic [0:OPB_DWIDTH-1]  xfer_wdata;
  logic                   xfer_rnw;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  // 0 is unmapped, 1 the read register, 2 the write register.
  function automatic int decode_window(input logic [0:OPB_AWIDTH-1] addr);
    if (addr >= S2P_BASEADDR && addr <= S2P_HIGHADDR) begin
      return 1;
    end
    if (addr >= P2S_BASEADDR && addr <= P2S_HIGHADDR) begin
      return 2;
    end
    return 0;
  endfunction

  // be bit 0 covers the most significant byte.
  function automatic logic [0:OPB_DWIDTH-1] merge_bytes(input logic [0:OPB_DWIDTH-1] old_word,
                                                        input logic [0:OPB_DWIDTH-1] new_word,
                                                        input logic [0:OPB_BEWIDTH-1] be);
    logic [0:OPB_DWIDTH-1] mask;
    mask = {{8{be[0]}}, {8{be[1]}}, {8{be[2]}}, {8{be[3]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic [0:OPB_DWIDTH-1] expected_read(input logic [0:OPB_AWIDTH-1] addr);
    case (decode_window(addr))
      1: return s2p_cur;
      2: return p2s_model;
      default: return '0;
    endcase
  endfunction

  // --------------------------------------------------
  // reporting
  // --------------------------------------------------
  task automatic mismatch(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
    err_count++;
    test_errs++;
  endtask

  task automatic protocol_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_count++;
    test_errs++;
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (test_errs == 0) begin
      $display("test %0d %s: pass", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic print_counts();
    $display("%0d transfers checked, %0d errors", check_count, err_count);
  endtask

  // --------------------------------------------------
  // comparison
  // --------------------------------------------------

  // user_data_out must carry the merged stored word.
  task automatic check_user_output();
    if (user_data_out !== p2s_model) begin
      mismatch("user_data_out", p2s_model, user_data_out);
    end
  endtask

  task automatic check_transfer();
    int                    win;
    logic [0:OPB_DWIDTH-1] exp_data;
    win      = decode_window(xfer_addr);
    exp_data = expected_read(xfer_addr);
    check_count++;
    if (Sl_xferAck !== (win != 0)) begin
      mismatch("Sl_xferAck", win != 0, Sl_xferAck);
    end
    if (Sl_errAck !== (win == 0)) begin
      mismatch("Sl_errAck", win == 0, Sl_errAck);
    end
    if (xfer_rnw && win != 0) begin
      // an unlocked buffer may have taken the current user value.
      if (win == 1 && !s2p_lock && Sl_DBus === user_data_in) begin
        s2p_cur = user_data_in;
      end else if (Sl_DBus !== exp_data) begin
        mismatch("Sl_DBus", exp_data, Sl_DBus);
      end
      if (win == 1 && xfer_be[0]) begin
        s2p_lock = 1'b1;
      end
      if (win == 1 && xfer_be[3]) begin
        s2p_lock = 1'b0;
      end
    end else if (!xfer_rnw && win == 2) begin
      p2s_model = merge_bytes(p2s_model, xfer_wdata, xfer_be);
    end
  endtask

  // outputs settle after the rising edge, so sample on the falling one.
  always @(negedge OPB_Clk) begin
    if (rst_n) begin
      if (Sl_retry !== 1'b0 || Sl_toutSup !== 1'b0) begin
        protocol_error("Sl_retry or Sl_toutSup is not low");
      end
      if (!(Sl_xferAck && OPB_RNW) && Sl_DBus !== '0) begin
        mismatch("Sl_DBus", 32'h0, Sl_DBus);
      end
      if (pending) begin
        age++;
      end
      if (Sl_xferAck || Sl_errAck) begin
        if (pending && age == 1) begin
          check_transfer();
        end else begin
          protocol_error("acknowledge without a select one cycle earlier");
        end
        pending = 1'b0;
      end else if (pending && age >= 1) begin
        protocol_error("no acknowledge one cycle after the select");
        pending = 1'b0;
      end
      if (OPB_select && !sel_prev) begin
        pending    = 1'b1;
        age        = 0;
        xfer_addr  = OPB_ABus;
        xfer_be    = OPB_BE;
        xfer_wdata = OPB_DBus;
        xfer_rnw   = OPB_RNW;
      end
      sel_prev = OPB_select;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import opb_regs_pkg::*;

  localparam logic [0:OPB_AWIDTH-1] UNMAPPED_ADDR = 32'h0000_0200;

  logic                   OPB_Clk;
  logic                   rst_n;
  logic [0:OPB_AWIDTH-1]  OPB_ABus;
  logic [0:OPB_BEWIDTH-1] OPB_BE;
  logic [0:OPB_DWIDTH-1]  OPB_DBus;
  logic                   OPB_RNW;
  logic                   OPB_select;
  logic                   OPB_seqAddr;
  logic                   user_clk;
  logic [OPB_DWIDTH-1:0]  user_data_in;
  wire  [OPB_DWIDTH-1:0]  user_data_out;
  wire  [0:OPB_DWIDTH-1]  Sl_DBus;
  wire                    Sl_xferAck;
  wire                    Sl_errAck;
  wire                    Sl_retry;
  wire                    Sl_toutSup;

  integer                 seed;
  logic [0:OPB_DWIDTH-1]  rd_data;
  logic [0:OPB_DWIDTH-1]  wr_data;
  logic [0:OPB_AWIDTH-1]  rnd_addr;

  opb_sw_reg_bank dut (.*);
  tb_checker u_checker (.*);

  initial OPB_Clk = 1'b0;
  always #50 OPB_Clk = ~OPB_Clk;

  // user edges fall on multiples of 70 ns and never on the stimulus times.
  initial user_clk = 1'b1;
  always #35 user_clk = ~user_clk;

  // --------------------------------------------------
  // bus master tasks
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    u_checker.print_counts();
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic release_bus();
    OPB_ABus   = '0;
    OPB_BE     = '0;
    OPB_DBus   = '0;
    OPB_RNW    = 1'b0;
    OPB_select = 1'b0;
  endtask

  // one select that is held until either ack and released one cycle later.
  task automatic bus_access(input logic [0:OPB_AWIDTH-1] addr, input logic [0:3] be,
                            input logic rnw, input logic [0:OPB_DWIDTH-1] wdata,
                            output logic [0:OPB_DWIDTH-1] rdata);
    int   cycles;
    logic acked;
    cycles = 0;
    acked  = 1'b0;
    @(posedge OPB_Clk);
    #5;
    OPB_ABus   = addr;
    OPB_BE     = be;
    OPB_RNW    = rnw;
    OPB_DBus   = rnw ? '0 : wdata;
    OPB_select = 1'b1;
    while (!acked && cycles < 20) begin
      @(posedge OPB_Clk);
      #5;
      acked = Sl_xferAck || Sl_errAck;
      cycles++;
    end
    if (!acked) begin
      abort_run("no acknowledge within 20 cycles of a select");
    end
    rdata = Sl_DBus;
    @(posedge OPB_Clk);
    #5;
    release_bus();
  endtask

  task automatic poll_s2p_value(input logic [OPB_DWIDTH-1:0] target);
    int                    tries;
    logic [0:OPB_DWIDTH-1] got;
    tries = 0;
    bus_access(S2P_BASEADDR, 4'b1111, 1'b1, '0, got);
    while (got != target && tries < 40) begin
      bus_access(S2P_BASEADDR, 4'b1111, 1'b1, '0, got);
      tries++;
    end
    if (got != target) begin
      abort_run("read register never returned the new user value");
    end
  endtask

  // the checker compares the word once it arrives or the wait runs out.
  task automatic await_user_output();
    int cycles;
    cycles = 0;
    while (user_data_out !== u_checker.p2s_model && cycles < 60) begin
      @(posedge OPB_Clk);
      #5;
      cycles++;
    end
    u_checker.check_user_output();
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    seed         = 32'h699b;
    rst_n        = 1'b0;
    OPB_seqAddr  = 1'b0;
    user_data_in = '0;
    release_bus();
    repeat (2) @(posedge OPB_Clk);
    #5;
    rst_n = 1'b1;
    // give both synchronizer loops time to settle.
    repeat (10) @(posedge OPB_Clk);
    #5;

    user_data_in = $random(seed);
    poll_s2p_value(user_data_in);
    u_checker.end_test("read register follows user data");

    bus_access(S2P_BASEADDR, 4'b1000, 1'b1, '0, rd_data);
    user_data_in = $random(seed);
    repeat (30) @(posedge OPB_Clk);
    bus_access(S2P_BASEADDR, 4'b0001, 1'b1, '0, rd_data);
    poll_s2p_value(user_data_in);
    u_checker.end_test("half word lock");

    wr_data = $random(seed);
    bus_access(P2S_BASEADDR, 4'b1111, 1'b0, wr_data, rd_data);
    wr_data = $random(seed);
    bus_access(P2S_BASEADDR, 4'b1000, 1'b0, wr_data, rd_data);
    wr_data = $random(seed);
    bus_access(P2S_BASEADDR, 4'b0010, 1'b0, wr_data, rd_data);
    wr_data = $random(seed);
    bus_access(P2S_BASEADDR, 4'b0101, 1'b0, wr_data, rd_data);
    await_user_output();
    u_checker.end_test("byte enabled writes reach user_data_out");

    bus_access(P2S_BASEADDR, 4'b1111, 1'b1, '0, rd_data);
    u_checker.end_test("write register read back");

    bus_access(UNMAPPED_ADDR, 4'b1111, 1'b1, '0, rd_data);
    bus_access(UNMAPPED_ADDR, 4'b1111, 1'b0, 32'hA5A5_5A5A, rd_data);
    u_checker.end_test("unmapped address error ack");

    // mixed traffic over both windows and the unmapped range.
    for (int i = 0; i < 16; i++) begin
      rnd_addr = $random(seed) & 32'h0000_02FF;
      wr_data  = $random(seed);
      bus_access(rnd_addr, wr_data[0:3], wr_data[31], wr_data, rd_data);
    end
    u_checker.end_test("mixed traffic and ack timing");

    u_checker.print_counts();
    if (u_checker.err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
